// ==== all.f ====
+incdir+include
hw/rename_pkg.sv
hw/dispatch_decoder.sv
hw/free_list.sv
hw/map_entry.sv
hw/operand_lookup.sv
hw/rename_top.sv
dv/rename_properties.sv
dv/rename_tb.sv

// ==== Bender.yml ====
package:
  name: rename

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/rename_pkg.sv
      - hw/dispatch_decoder.sv
      - hw/free_list.sv
      - hw/map_entry.sv
      - hw/operand_lookup.sv
      - hw/rename_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/rename_properties.sv
      - dv/rename_tb.sv

// ==== dv/rename_tb.sv ====
// rename testbench: random dispatch, wake-up, retire and rollback checked against a reference model
`timescale 1ns/100ps
`include "rename_defines.svh"

module rename_tb;

  import rename_pkg::*;

  localparam int FL_DEPTH    = `NUM_PHYS_TAGS - `NUM_ARCH_REGS;
  localparam int STIM_CYCLES = 2000;
  localparam int MAX_CYCLES  = STIM_CYCLES + 1000;  // reset and drain margin
  localparam int MAX_FLIGHT  = 40;  // more than FL_DEPTH, lets the free list run dry

  typedef struct packed {
    logic      ok;
    phys_tag_t t_new;
    phys_tag_t t_old;
    phys_tag_t t1;
    logic      t1_ready;
    phys_tag_t t2;
    logic      t2_ready;
  } expect_t;

  // one in-flight instruction as the rob sees it
  typedef struct packed {
    rob_idx_t  idx;
    arch_reg_t dest;
    phys_tag_t told;
    phys_tag_t tnew;
  } flight_t;

  logic      clock;
  logic      reset;
  logic      dispatch_en;
  arch_reg_t reg_dest;
  arch_reg_t reg_a;
  arch_reg_t reg_b;
  rob_idx_t  rob_tail_idx;
  logic      cdb_en;
  phys_tag_t cdb_tag;
  logic      retire_en;
  phys_tag_t retire_told;
  logic      rollback_en;
  rob_idx_t  rollback_idx;
  logic      dispatch_ok;
  phys_tag_t t_new;
  phys_tag_t t_old;
  phys_tag_t t1;
  logic      t1_ready;
  phys_tag_t t2;
  logic      t2_ready;

  // reference state
  phys_tag_t m_tag  [`NUM_ARCH_REGS];
  logic      m_rdy  [`NUM_ARCH_REGS];
  phys_tag_t c_tag  [`NUM_ROB][`NUM_ARCH_REGS];  // map copy per rob slot
  logic      c_rdy  [`NUM_ROB][`NUM_ARCH_REGS];
  int        c_head [`NUM_ROB];
  phys_tag_t fl_buf [FL_DEPTH];  // free tags, read at fl_head
  int        fl_head;
  int        fl_tail;

  flight_t   flight[$];  // oldest first
  int        intact = 0;  // youngest flight entries still owning their slot
  rob_idx_t  rob_next;
  integer    seed;
  int        cycles = 0;
  int        errors = 0;
  int        checks = 0;
  int        empties = 0;  // cycles seen with no free tag
  int        rollbacks = 0;

  rename_top rename_top_i (.*);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  function automatic int pick_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic model_reset();
    for (int r = 0; r < `NUM_ARCH_REGS; r++) begin
      m_tag[r] = phys_tag_t'(r);  // identity map
      m_rdy[r] = 1'b1;
    end
    for (int i = 0; i < FL_DEPTH; i++) fl_buf[i] = phys_tag_t'(`NUM_ARCH_REGS + i);
    fl_head = 0;
    fl_tail = FL_DEPTH;
  endtask

  // one clock edge of the rename rules
  task automatic model_step();
    phys_tag_t n_tag [`NUM_ARCH_REGS];
    logic      n_rdy [`NUM_ARCH_REGS];
    logic      accept;
    accept = dispatch_en && (fl_head != fl_tail) && !rollback_en;
    for (int r = 0; r < `NUM_ARCH_REGS; r++) begin
      n_tag[r] = m_tag[r];
      n_rdy[r] = m_rdy[r] || (cdb_en && (m_tag[r] == cdb_tag));
    end
    if (accept && (reg_dest != `ZERO_REG)) begin
      n_tag[reg_dest] = fl_buf[fl_head % FL_DEPTH];  // new producer, not ready
      n_rdy[reg_dest] = 1'b0;
      fl_head++;
    end
    if (rollback_en) begin
      m_tag   = c_tag[rollback_idx];  // copy before this cycle's wake-up
      m_rdy   = c_rdy[rollback_idx];
      fl_head = c_head[rollback_idx];
    end else begin
      m_tag = n_tag;
      m_rdy = n_rdy;
    end
    for (int s = 0; s < `NUM_ROB; s++) begin
      for (int r = 0; r < `NUM_ARCH_REGS; r++) begin
        if (cdb_en && (c_tag[s][r] == cdb_tag)) c_rdy[s][r] = 1'b1;
      end
    end
    if (accept) begin
      c_tag[rob_tail_idx]  = n_tag;  // map after the dispatch
      c_rdy[rob_tail_idx]  = n_rdy;
      c_head[rob_tail_idx] = fl_head;
    end
    if (retire_en) begin
      fl_buf[fl_tail % FL_DEPTH] = retire_told;  // back of the queue
      fl_tail++;
    end
  endtask

  // expected outputs from the model and the present inputs
  function automatic expect_t predict();
    expect_t e;
    e.ok       = (fl_head != fl_tail);
    e.t_new    = fl_buf[fl_head % FL_DEPTH];
    e.t_old    = m_tag[reg_dest];
    e.t1       = m_tag[reg_a];
    e.t1_ready = m_rdy[reg_a] || (cdb_en && (m_tag[reg_a] == cdb_tag));
    e.t2       = m_tag[reg_b];
    e.t2_ready = m_rdy[reg_b] || (cdb_en && (m_tag[reg_b] == cdb_tag));
    return e;
  endfunction

  task automatic report_mismatch(input string name, input logic [7:0] got,
                                 input logic [7:0] exp);
    errors++;
    $display("Fail %s: got %h expected %h at cycle %0d", name, got, exp, cycles);
  endtask

  task automatic check_outputs();
    expect_t e;
    e = predict();
    checks++;
    if (!e.ok) empties++;
    if (dispatch_ok !== e.ok) report_mismatch("dispatch_ok", dispatch_ok, e.ok);
    if (e.ok && (t_new !== e.t_new)) report_mismatch("t_new", t_new, e.t_new);  // head stale when dry
    if (t_old !== e.t_old) report_mismatch("t_old", t_old, e.t_old);
    if (t1 !== e.t1) report_mismatch("t1", t1, e.t1);
    if (t1_ready !== e.t1_ready) report_mismatch("t1_ready", t1_ready, e.t1_ready);
    if (t2 !== e.t2) report_mismatch("t2", t2, e.t2);
    if (t2_ready !== e.t2_ready) report_mismatch("t2_ready", t2_ready, e.t2_ready);
  endtask

  // plays decoder, rob and execute units for one cycle
  task automatic drive_cycle(input int cyc);
    flight_t f;
    int      k;
    int      n;
    logic    heavy;
    heavy       = (cyc % 500) < 150;  // dispatch-heavy stretch drains the free list
    dispatch_en = 1'b0;
    retire_en   = 1'b0;
    rollback_en = 1'b0;
    cdb_en      = 1'b0;
    reg_a       = arch_reg_t'(pick_below(`NUM_ARCH_REGS));
    reg_b       = arch_reg_t'(pick_below(`NUM_ARCH_REGS));
    reg_dest    = arch_reg_t'(pick_below(`NUM_ARCH_REGS));
    if ((flight.size() > 0) && (pick_below(100) < (heavy ? 3 : 40))) begin
      f           = flight.pop_front();
      retire_en   = (f.dest != `ZERO_REG);  // r31 frees nothing
      retire_told = f.told;
      if (intact > flight.size()) begin
        intact = flight.size();  // oldest left the window
      end
    end
    if ((flight.size() > 0) && (pick_below(100) < 4)) begin
      n = (flight.size() < intact) ? flight.size() : intact;  // slots still intact
      k = flight.size() - 1 - pick_below(n);
      rollback_en  = 1'b1;
      rollback_idx = flight[k].idx;
      rob_next     = flight[k].idx + 1'b1;
      intact       = intact - (flight.size() - 1 - k);  // squashed ones took older slots
      while (flight.size() > k + 1) void'(flight.pop_back());  // squash younger
      rollbacks++;
    end else if ((flight.size() < MAX_FLIGHT) && (pick_below(100) < (heavy ? 90 : 50))) begin
      dispatch_en  = 1'b1;
      rob_tail_idx = rob_next;
      if (fl_head != fl_tail) begin  // taken, not back-pressured
        f.idx  = rob_next;
        f.dest = reg_dest;
        f.told = m_tag[reg_dest];
        f.tnew = fl_buf[fl_head % FL_DEPTH];
        flight.push_back(f);
        rob_next++;
        if (intact < `NUM_ROB) begin
          intact++;
        end
      end
    end
    if (pick_below(100) < 30) begin
      cdb_en  = 1'b1;
      cdb_tag = phys_tag_t'(pick_below(`NUM_PHYS_TAGS));
      if ((flight.size() > 0) && (pick_below(3) != 0)) begin
        cdb_tag = flight[pick_below(flight.size())].tnew;  // mostly real producers
      end
    end
  endtask

  always @(posedge clock) begin
    if (reset) model_reset();
    else model_step();
  end

  always @(negedge clock) begin
    if (!reset) check_outputs();  // inputs settled since posedge + 1
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run still going after %0d cycles", MAX_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    seed         = 88847;
    reset        = 1'b1;
    dispatch_en  = 1'b0;
    reg_dest     = '0;
    reg_a        = '0;
    reg_b        = '0;
    rob_tail_idx = '0;
    cdb_en       = 1'b0;
    cdb_tag      = '0;
    retire_en    = 1'b0;
    retire_told  = '0;
    rollback_en  = 1'b0;
    rollback_idx = '0;
    rob_next     = '0;
    repeat (5) @(posedge clock);
    #1 reset = 1'b0;
    // every register on both sources and the destination, reset map untouched
    for (int r = 0; r < `NUM_ARCH_REGS; r++) begin
      @(posedge clock);
      #1;
      reg_a    = arch_reg_t'(r);
      reg_b    = arch_reg_t'(`NUM_ARCH_REGS - 1 - r);
      reg_dest = arch_reg_t'(r);
    end
    for (int c = 0; c < STIM_CYCLES; c++) begin
      @(posedge clock);
      #1;
      drive_cycle(c);
    end
    repeat (2) @(posedge clock);  // last check at the negedge in between
    errors += rename_top_i.rename_properties_i.assert_fails;  // bound checker
    if (empties == 0) begin
      errors++;
      $display("free list never ran empty, back-pressure not exercised");
    end
    if (rollbacks == 0) begin
      errors++;
      $display("no rollback was issued");
    end
    $display("checks %0d errors %0d rollbacks %0d empty cycles %0d",
             checks, errors, rollbacks, empties);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== dv/rename_properties.sv ====
// rename assertions: reset state, hardwired register and uniqueness of the handed-out tag
`timescale 1ns/100ps
`include "rename_defines.svh"

module rename_properties (
  input logic                                       clock,
  input logic                                       reset,
  input logic                                       dispatch_en,
  input logic                                       rollback_en,
  input rename_pkg::arch_reg_t                      reg_dest,
  input rename_pkg::arch_reg_t                      reg_a,
  input logic                                       dispatch_ok,
  input rename_pkg::phys_tag_t                      t_new,
  input rename_pkg::phys_tag_t                      t1,
  input logic                                       t1_ready,
  input rename_pkg::phys_tag_t [`NUM_ARCH_REGS-1:0] entry_tag,   // live map
  input logic                  [`NUM_ARCH_REGS-1:0] entry_ready
);

  import rename_pkg::*;

  logic taking;          // accepted dispatch that pops a tag
  int   assert_fails = 0;  // failed assertion count

  assign taking = dispatch_en && dispatch_ok && !rollback_en && (reg_dest != `ZERO_REG);

  // true when some register already maps to tg
  function automatic logic tag_mapped(input phys_tag_t tg,
                                      input phys_tag_t [`NUM_ARCH_REGS-1:0] map);
    for (int r = 0; r < `NUM_ARCH_REGS; r++) begin
      if (map[r] == tg) return 1'b1;
    end
    return 1'b0;
  endfunction

  // free list starts full, so the front end may go at once
  ok_after_reset: assert property (@(posedge clock) reset |=> dispatch_ok)
    else begin
      $error("dispatch_ok low right after reset");
      assert_fails++;
    end

  zero_reg_entry: assert property (@(posedge clock) disable iff (reset)
      (entry_tag[`ZERO_REG] == `ZERO_REG) && entry_ready[`ZERO_REG])
    else begin
      $error("register 31 entry left tag 31 or lost ready");
      assert_fails++;
    end

  zero_reg_read: assert property (@(posedge clock) disable iff (reset)
      (reg_a == `ZERO_REG) |-> ((t1 == `ZERO_REG) && t1_ready))
    else begin
      $error("lookup of register 31 not tag 31 ready");
      assert_fails++;
    end

  // a fresh tag must be unmapped, else two registers alias
  fresh_tag: assert property (@(posedge clock) disable iff (reset)
      taking |-> !tag_mapped(t_new, entry_tag))
    else begin
      $error("t_new already held by a live mapping");
      assert_fails++;
    end

endmodule

bind rename_top rename_properties rename_properties_i (
  .clock       (clock),
  .reset       (reset),
  .dispatch_en (dispatch_en),
  .rollback_en (rollback_en),
  .reg_dest    (reg_dest),
  .reg_a       (reg_a),
  .dispatch_ok (dispatch_ok),
  .t_new       (t_new),
  .t1          (t1),
  .t1_ready    (t1_ready),
  .entry_tag   (entry_tag),
  .entry_ready (entry_ready)
);

// ==== hw/rename_top.sv ====
// rename top: map table, free list and dispatch decode for one instruction per cycle
`timescale 1ns/100ps
`include "rename_defines.svh"

module rename_top (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  dispatch_en,
  input  rename_pkg::arch_reg_t reg_dest,
  input  rename_pkg::arch_reg_t reg_a,
  input  rename_pkg::arch_reg_t reg_b,
  input  rename_pkg::rob_idx_t  rob_tail_idx,  // slot of the dispatching instruction
  input  logic                  cdb_en,
  input  rename_pkg::phys_tag_t cdb_tag,
  input  logic                  retire_en,
  input  rename_pkg::phys_tag_t retire_told,
  input  logic                  rollback_en,
  input  rename_pkg::rob_idx_t  rollback_idx,
  output logic                  dispatch_ok,
  output rename_pkg::phys_tag_t t_new,         // tag given to the destination
  output rename_pkg::phys_tag_t t_old,
  output rename_pkg::phys_tag_t t1,
  output logic                  t1_ready,
  output rename_pkg::phys_tag_t t2,
  output logic                  t2_ready
);

  import rename_pkg::*;

  logic                      empty;       // free list drained
  logic                      pop;
  logic                      checkpoint;  // to free list and every entry
  logic [`NUM_ARCH_REGS-1:0] write_sel;   // one-hot destination strobe

  phys_tag_t [`NUM_ARCH_REGS-1:0] entry_tag;  // live map, gathered for lookup
  logic      [`NUM_ARCH_REGS-1:0] entry_ready;

  dispatch_decoder dispatch_decoder_i (
    .dispatch_en (dispatch_en),
    .reg_dest    (reg_dest),
    .empty       (empty),
    .rollback_en (rollback_en),
    .dispatch_ok (dispatch_ok),
    .pop         (pop),
    .write_sel   (write_sel),
    .checkpoint  (checkpoint)
  );

  free_list free_list_i (
    .clock        (clock),
    .reset        (reset),
    .pop          (pop),
    .checkpoint   (checkpoint),
    .rob_tail_idx (rob_tail_idx),
    .retire_en    (retire_en),
    .retire_told  (retire_told),
    .rollback_en  (rollback_en),
    .rollback_idx (rollback_idx),
    .head_tag     (t_new),  // also the tag written into the entry
    .empty        (empty)
  );

  // one entry per architectural register, reset to its own number
  for (genvar i = 0; i < `NUM_ARCH_REGS; i++) begin : g_entry
    map_entry map_entry_i (
      .clock        (clock),
      .reset        (reset),
      .init_tag     (phys_tag_t'(i)),
      .write        (write_sel[i]),
      .new_tag      (t_new),
      .checkpoint   (checkpoint),
      .rob_tail_idx (rob_tail_idx),
      .cdb_en       (cdb_en),
      .cdb_tag      (cdb_tag),
      .rollback_en  (rollback_en),
      .rollback_idx (rollback_idx),
      .tag          (entry_tag[i]),
      .ready        (entry_ready[i])
    );
  end

  operand_lookup operand_lookup_i (
    .entry_tag   (entry_tag),
    .entry_ready (entry_ready),
    .reg_a       (reg_a),
    .reg_b       (reg_b),
    .reg_dest    (reg_dest),
    .cdb_en      (cdb_en),
    .cdb_tag     (cdb_tag),
    .t1          (t1),
    .t1_ready    (t1_ready),
    .t2          (t2),
    .t2_ready    (t2_ready),
    .t_old       (t_old)
  );

endmodule

// ==== hw/operand_lookup.sv ====
// operand lookup: reads source and old destination mappings with same-cycle cdb forwarding
`timescale 1ns/100ps
`include "rename_defines.svh"

module operand_lookup (
  input  rename_pkg::phys_tag_t [`NUM_ARCH_REGS-1:0] entry_tag,    // live tags, by register
  input  logic                  [`NUM_ARCH_REGS-1:0] entry_ready,
  input  rename_pkg::arch_reg_t                      reg_a,
  input  rename_pkg::arch_reg_t                      reg_b,
  input  rename_pkg::arch_reg_t                      reg_dest,
  input  logic                                       cdb_en,
  input  rename_pkg::phys_tag_t                      cdb_tag,
  output rename_pkg::phys_tag_t                      t1,
  output logic                                       t1_ready,
  output rename_pkg::phys_tag_t                      t2,
  output logic                                       t2_ready,
  output rename_pkg::phys_tag_t                      t_old   // goes to the rob, freed at retire
);

  import rename_pkg::*;

  // stored ready, or the producer is on the cdb right now
  function automatic logic woken(input phys_tag_t src_tag, input logic src_ready,
                                 input logic bcast_en, input phys_tag_t bcast_tag);
    return src_ready || (bcast_en && (src_tag == bcast_tag));
  endfunction

  assign t1    = entry_tag[reg_a];
  assign t2    = entry_tag[reg_b];
  assign t_old = entry_tag[reg_dest];  // mapping before this dispatch lands

  // forwarding keeps the rs from missing a wake-up in the dispatch cycle
  always_comb begin
    t1_ready = woken(t1, entry_ready[reg_a], cdb_en, cdb_tag);
    t2_ready = woken(t2, entry_ready[reg_b], cdb_en, cdb_tag);
  end

endmodule

// ==== hw/map_entry.sv ====
// map entry: live tag and ready bit of one architectural register plus its rob-slot checkpoints
`timescale 1ns/100ps
`include "rename_defines.svh"

module map_entry (
  input  logic                  clock,
  input  logic                  reset,
  input  rename_pkg::phys_tag_t init_tag,     // reset mapping, tied per entry
  input  logic                  write,        // this register is the destination
  input  rename_pkg::phys_tag_t new_tag,      // free-list head
  input  logic                  checkpoint,
  input  rename_pkg::rob_idx_t  rob_tail_idx,
  input  logic                  cdb_en,
  input  rename_pkg::phys_tag_t cdb_tag,
  input  logic                  rollback_en,
  input  rename_pkg::rob_idx_t  rollback_idx,
  output rename_pkg::phys_tag_t tag,
  output logic                  ready
);

  import rename_pkg::*;

  phys_tag_t ckpt_tag   [`NUM_ROB];  // saved mapping per rob slot
  logic      ckpt_ready [`NUM_ROB];

  phys_tag_t next_tag;    // mapping after this cycle's dispatch and wake-up
  logic      next_ready;
  logic      cdb_hit;     // live tag completes now

  assign cdb_hit = cdb_en && (tag == cdb_tag);

  always_comb begin
    next_tag   = tag;
    next_ready = ready || cdb_hit;
    if (write) begin
      next_tag   = new_tag;  // renamed, producer not done yet
      next_ready = 1'b0;
    end
  end

  // live mapping
  always_ff @(posedge clock) begin
    if (reset) begin
      tag   <= init_tag;  // identity map, all values present
      ready <= 1'b1;
    end else if (rollback_en) begin
      tag   <= ckpt_tag[rollback_idx];  // restore beats dispatch and wake-up
      ready <= ckpt_ready[rollback_idx];
    end else begin
      tag   <= next_tag;
      ready <= next_ready;
    end
  end

  // checkpoint slots
  always_ff @(posedge clock) begin
    for (int s = 0; s < `NUM_ROB; s++) begin
      if (checkpoint && (rob_tail_idx == rob_idx_t'(s))) begin
        ckpt_tag[s]   <= next_tag;  // post-dispatch state
        ckpt_ready[s] <= next_ready;
      end else if (cdb_en && (ckpt_tag[s] == cdb_tag)) begin
        ckpt_ready[s] <= 1'b1;  // completion seen by saved copies too
      end
    end
  end

endmodule

// ==== hw/free_list.sv ====
// free list: circular queue of unmapped physical tags with per-rob-slot head checkpoints
`timescale 1ns/100ps
`include "rename_defines.svh"

module free_list (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  pop,           // dispatch takes head_tag
  input  logic                  checkpoint,    // save post-pop head
  input  rename_pkg::rob_idx_t  rob_tail_idx,  // slot for the saved head
  input  logic                  retire_en,
  input  rename_pkg::phys_tag_t retire_told,   // old tag freed at retire
  input  logic                  rollback_en,
  input  rename_pkg::rob_idx_t  rollback_idx,
  output rename_pkg::phys_tag_t head_tag,      // next tag handed out
  output logic                  empty
);

  import rename_pkg::*;

  // pointer = slot index plus one wrap bit, so full and empty differ
  typedef logic [$clog2(`NUM_PHYS_TAGS-`NUM_ARCH_REGS):0] fl_ptr_t;

  phys_tag_t free_buf [`NUM_PHYS_TAGS-`NUM_ARCH_REGS];  // oldest free tag at head

  fl_ptr_t head;        // read side, moved by dispatch and rollback
  fl_ptr_t tail;        // write side, moved by retire only
  fl_ptr_t head_next;   // head once this cycle's pop is done
  fl_ptr_t ckpt_head [`NUM_ROB];  // head as it stood after each slot's dispatch

  logic [$bits(fl_ptr_t)-2:0] head_idx;  // slot part of head
  logic [$bits(fl_ptr_t)-2:0] tail_idx;  // slot part of tail

  assign head_idx = head[$bits(fl_ptr_t)-2:0];
  assign tail_idx = tail[$bits(fl_ptr_t)-2:0];

  assign head_next = head + fl_ptr_t'(pop);

  assign head_tag = free_buf[head_idx];  // valid whenever not empty
  assign empty    = (head == tail);      // same slot, same wrap

  // pointer update
  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      // queue starts full: tail one lap ahead of head
      tail <= fl_ptr_t'(`NUM_PHYS_TAGS - `NUM_ARCH_REGS);
    end else begin
      if (rollback_en) begin
        // moving head back re-frees the squashed tags
        head <= ckpt_head[rollback_idx];
      end else begin
        head <= head_next;
      end
      if (retire_en) begin
        tail <= tail + 1'b1;  // retire push goes on during rollback too
      end
    end
  end

  // tag storage
  always_ff @(posedge clock) begin
    if (reset) begin
      // tags above the reset mapping, in ascending order
      for (int i = 0; i < `NUM_PHYS_TAGS - `NUM_ARCH_REGS; i++) begin
        free_buf[i] <= phys_tag_t'(`NUM_ARCH_REGS + i);
      end
    end else if (retire_en) begin
      free_buf[tail_idx] <= retire_told;  // freed tag joins at the back
    end
  end

  // head checkpoints
  // squashed tags still sit between the saved head and the live head,
  // retire cannot reach them while they are in flight
  always_ff @(posedge clock) begin
    if (checkpoint) begin
      ckpt_head[rob_tail_idx] <= head_next;
    end
  end

endmodule

// ==== hw/dispatch_decoder.sv ====
// dispatch decoder: accepts a dispatch and turns the destination into one-hot entry strobes
`timescale 1ns/100ps
`include "rename_defines.svh"

module dispatch_decoder (
  input  logic                       dispatch_en,  // decoder wants to rename
  input  rename_pkg::arch_reg_t      reg_dest,
  input  logic                       empty,        // no free tag left
  input  logic                       rollback_en,
  output logic                       dispatch_ok,  // back-pressure level
  output logic                       pop,          // take head tag from free list
  output logic [`NUM_ARCH_REGS-1:0]  write_sel,    // one-hot, to map entries
  output logic                       checkpoint    // snapshot map and free-list head
);

  logic accept;     // dispatch actually taken this cycle
  logic renamable;  // destination gets a fresh tag

  // only a non-empty free list lets the front end go
  assign dispatch_ok = !empty;

  // rollback steals the cycle, dispatch dropped
  assign accept = dispatch_en && dispatch_ok && !rollback_en;

  // the hardwired register keeps its tag
  assign renamable = (reg_dest != `ZERO_REG);

  assign pop = accept && renamable;

  // every accepted dispatch owns a rob slot, so it checkpoints
  // even when nothing gets renamed
  assign checkpoint = accept;

  // destination decode
  always_comb begin
    write_sel = '0;
    if (pop) begin
      write_sel[reg_dest] = 1'b1;  // single entry takes the new tag
    end
  end

endmodule

// ==== hw/rename_pkg.sv ====
// rename stage types for register numbers, physical tags and reorder-buffer slots
`include "rename_defines.svh"

package rename_pkg;

  // architectural register number, 5 bits
  typedef logic [$clog2(`NUM_ARCH_REGS)-1:0] arch_reg_t;

  // physical tag, 6 bits
  typedef logic [$clog2(`NUM_PHYS_TAGS)-1:0] phys_tag_t;

  // rob index, also picks the checkpoint slot
  typedef logic [$clog2(`NUM_ROB)-1:0] rob_idx_t;

endpackage

// ==== include/rename_defines.svh ====
// rename stage sizing: architectural registers, physical tags, rob depth, hardwired register
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// architectural register file seen by software
`define NUM_ARCH_REGS 32

// physical tag space
// the first NUM_ARCH_REGS tags are mapped at reset, the rest start out free
`define NUM_PHYS_TAGS 64

// reorder buffer slots, one map checkpoint per slot
`define NUM_ROB 16

// never renamed, always reads as its own tag and ready
`define ZERO_REG 31

`endif
